/* Bender.yml */
package:
  name: decoder

sources:
  # packages first, then the RTL bottom up.
  - src/xgmii_pkg.sv
  - src/pcs66_pkg.sv
  - src/decoder_comparator.sv
  - src/octet_decoder.sv
  - src/decoder_fsm.sv
  - src/decoder.sv
  - target: test
    files:
      - testbench/decoder_props.sv
      - testbench/tb_decoder.sv

/* decoder.f */
src/xgmii_pkg.sv
src/pcs66_pkg.sv
src/decoder_comparator.sv
src/octet_decoder.sv
src/decoder_fsm.sv
src/decoder.sv
testbench/decoder_props.sv
testbench/tb_decoder.sv

/* src/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_enable,
    input  pcs66_pkg::coded_block_t i_data,
    output xgmii_pkg::xgmii_data_t  o_data,
    output xgmii_pkg::xgmii_ctrl_t  o_ctrl,
    output pcs66_pkg::rx_state_e    o_fsm_control
);
    import pcs66_pkg::*;
    import xgmii_pkg::*;

    // comparator to octet decoders and fsm.
    classified_t                     fields;

    // octet decoders to fsm.
    xgmii_char_t [NB_CTRL_BLOCK-1:0] lane_chars;
    xgmii_ctrl_t                     lane_flags;
    xgmii_word_t                     lane_word;

    decoder_comparator u_decoder_comparator (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_enable    (i_enable),
        .i_rx_coded  (i_data),
        .o_rx_fields (fields)
    );

    // one decoder per XGMII lane.
    for (genvar i = 0; i < NB_CTRL_BLOCK; i++) begin : g_lane
        octet_decoder u_octet_decoder (
            .i_field   (fields.lanes[i]),
            .o_char    (lane_chars[i]),
            .o_is_ctrl (lane_flags[i])
        );
    end

    assign lane_word.data = lane_chars;
    assign lane_word.ctrl = lane_flags;

    decoder_fsm u_decoder_fsm (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_enable         (i_enable),
        .i_word           (lane_word),
        .i_r_type         (fields.cls),
        .o_rx_raw_data    (o_data),
        .o_rx_raw_control (o_ctrl),
        .o_fsm_state      (o_fsm_control)
    );

endmodule

/* src/decoder_comparator.sv */
`timescale 1ns/1ps

module decoder_comparator (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_enable,
    input  pcs66_pkg::coded_block_t i_rx_coded,
    output pcs66_pkg::classified_t  o_rx_fields
);
    import pcs66_pkg::*;
    import xgmii_pkg::*;

    sync_t                           sync;
    logic [7:0]                      block_type;
    logic [2:0]                      term_lane;
    blk_class_e                      cls_d;
    blk_class_e                      cls_q;
    lane_field_t [NB_CTRL_BLOCK-1:0] lanes_d;
    lane_field_t [NB_CTRL_BLOCK-1:0] lanes_q;

    assign sync       = i_rx_coded[NB_SYNC-1:0];
    assign block_type = i_rx_coded[NB_SYNC +: 8];

    // base is the bit where lane 0 would start.
    function automatic lane_field_t data_lane(coded_block_t blk, int base, int lane);
        lane_field_t f;
        f.kind  = LANE_DATA;
        f.octet = blk[base + 8*lane +: 8];
        f.fixed = XGMII_IDLE;
        return f;
    endfunction

    // codes are packed 7 bits apart right after the type field.
    function automatic lane_field_t code_lane(coded_block_t blk, int lane);
        lane_field_t f;
        f.kind  = LANE_CODE;
        f.octet = {1'b0, blk[10 + 7*lane +: 7]};
        f.fixed = XGMII_IDLE;
        return f;
    endfunction

    function automatic lane_field_t fixed_lane(xgmii_char_t ch);
        lane_field_t f;
        f.kind  = LANE_FIXED;
        f.octet = ch;
        f.fixed = ch;
        return f;
    endfunction

    // terminate position from the type code.
    always_comb begin
        case (block_type)
            BT_TERM1: term_lane = 3'd1;
            BT_TERM2: term_lane = 3'd2;
            BT_TERM3: term_lane = 3'd3;
            BT_TERM4: term_lane = 3'd4;
            BT_TERM5: term_lane = 3'd5;
            BT_TERM6: term_lane = 3'd6;
            BT_TERM7: term_lane = 3'd7;
            default:  term_lane = 3'd0;
        endcase
    end

    always_comb begin
        cls_d = CLS_E;
        for (int j = 0; j < NB_CTRL_BLOCK; j++) begin
            lanes_d[j] = data_lane(i_rx_coded, 2, j);
        end
        if (sync == SYNC_DATA) begin
            cls_d = CLS_D;
        end else if (sync == SYNC_CTRL) begin
            case (block_type)
                BT_CTRL: begin
                    cls_d = CLS_C;
                    for (int j = 0; j < NB_CTRL_BLOCK; j++) begin
                        lanes_d[j] = code_lane(i_rx_coded, j);
                    end
                end
                BT_START0: begin
                    cls_d      = CLS_S;
                    lanes_d[0] = fixed_lane(XGMII_START);
                end
                BT_START4: begin
                    cls_d = CLS_S;
                    for (int j = 0; j < 4; j++) begin
                        lanes_d[j] = code_lane(i_rx_coded, j);
                    end
                    lanes_d[4] = fixed_lane(XGMII_START);
                end
                // second half of the ordered set is not decoded.
                BT_ORDSET: begin
                    cls_d      = CLS_C;
                    lanes_d[0] = fixed_lane(XGMII_SEQ);
                    for (int j = 4; j < NB_CTRL_BLOCK; j++) begin
                        lanes_d[j] = fixed_lane(XGMII_IDLE);
                    end
                end
                BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
                BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7: begin
                    cls_d = CLS_T;
                    for (int j = 0; j < NB_CTRL_BLOCK; j++) begin
                        if (j < term_lane) begin
                            lanes_d[j] = data_lane(i_rx_coded, 10, j);
                        end else if (j == term_lane) begin
                            lanes_d[j] = fixed_lane(XGMII_TERM);
                        end else begin
                            lanes_d[j] = code_lane(i_rx_coded, j);
                        end
                    end
                end
                default: cls_d = CLS_E;
            endcase
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cls_q <= CLS_E;
        end else if (i_enable) begin
            cls_q <= cls_d;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_enable) begin
            lanes_q <= lanes_d;
        end
    end

    assign o_rx_fields.cls   = cls_q;
    assign o_rx_fields.lanes = lanes_q;

endmodule

/* src/decoder_fsm.sv */
`timescale 1ns/1ps

module decoder_fsm (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_enable,
    input  xgmii_pkg::xgmii_word_t  i_word,
    input  pcs66_pkg::blk_class_e   i_r_type,
    output xgmii_pkg::xgmii_data_t  o_rx_raw_data,
    output xgmii_pkg::xgmii_ctrl_t  o_rx_raw_control,
    output pcs66_pkg::rx_state_e    o_fsm_state
);
    import pcs66_pkg::*;
    import xgmii_pkg::*;

    xgmii_word_t word_q;
    blk_class_e  cls_q;
    rx_state_e   state_q;
    rx_state_e   state_d;
    xgmii_data_t data_q;
    xgmii_ctrl_t ctrl_q;
    logic        from_idle;
    logic        from_data;
    logic        next_ok;

    // lookahead, so the incoming class is the next type.
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cls_q <= CLS_E;
        end else if (i_enable) begin
            cls_q <= i_r_type;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_enable) begin
            word_q <= i_word;
        end
    end

    assign from_idle = (state_q == RX_INIT) || (state_q == RX_C) ||
                       (state_q == RX_T) || (state_q == RX_E);
    assign from_data = (state_q == RX_D) || (state_q == RX_E);

    // a terminate must be followed by idle or a new start.
    assign next_ok = (i_r_type == CLS_C) || (i_r_type == CLS_S);

    always_comb begin
        if (from_idle && (cls_q == CLS_C)) begin
            state_d = RX_C;
        end else if (from_idle && (cls_q == CLS_S)) begin
            state_d = RX_D;
        end else if (from_data && (cls_q == CLS_D)) begin
            state_d = RX_D;
        end else if (from_data && (cls_q == CLS_T) && next_ok) begin
            state_d = RX_T;
        end else begin
            state_d = RX_E;
        end
    end

    // error state replaces the whole block.
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= RX_INIT;
            data_q  <= '0;
            ctrl_q  <= '0;
        end else if (i_enable) begin
            state_q <= state_d;
            if (state_d == RX_E) begin
                data_q <= {NB_CTRL_BLOCK{XGMII_ERROR}};
                ctrl_q <= '1;
            end else begin
                data_q <= word_q.data;
                ctrl_q <= word_q.ctrl;
            end
        end
    end

    assign o_rx_raw_data    = data_q;
    assign o_rx_raw_control = ctrl_q;
    assign o_fsm_state      = state_q;

endmodule

/* src/octet_decoder.sv */
`timescale 1ns/1ps

module octet_decoder (
    input  pcs66_pkg::lane_field_t  i_field,
    output xgmii_pkg::xgmii_char_t  o_char,
    output logic                    o_is_ctrl
);
    import pcs66_pkg::*;
    import xgmii_pkg::*;

    ctrl_code_t code;

    // bit 7 of a code lane is padding.
    assign code = i_field.octet[6:0];

    always_comb begin
        o_char    = i_field.octet;
        o_is_ctrl = 1'b0;
        case (i_field.kind)
            LANE_CODE: begin
                o_is_ctrl = 1'b1;
                case (code)
                    CODE_IDLE:  o_char = XGMII_IDLE;
                    CODE_ERROR: o_char = XGMII_ERROR;
                    // unsupported codes are reported as error.
                    default:    o_char = XGMII_ERROR;
                endcase
            end
            LANE_FIXED: begin
                o_is_ctrl = 1'b1;
                o_char    = i_field.fixed;
            end
            default: begin
                o_is_ctrl = 1'b0;
                o_char    = i_field.octet;
            end
        endcase
    end

endmodule

/* src/pcs66_pkg.sv */
package pcs66_pkg;

    // coded side of the PCS receive path.
    localparam int NB_DATA_CODED = 66;
    localparam int NB_SYNC       = 2;
    localparam int NB_BLOCK_TYPE = 4;

    typedef logic [NB_DATA_CODED-1:0] coded_block_t;
    typedef logic [NB_SYNC-1:0]       sync_t;

    // sync header, bits 1:0 of the block.
    localparam sync_t SYNC_DATA = 2'b01;
    localparam sync_t SYNC_CTRL = 2'b10;

    // 7-bit control code packed in control blocks.
    typedef logic [6:0] ctrl_code_t;

    localparam ctrl_code_t CODE_IDLE  = 7'h00;
    localparam ctrl_code_t CODE_ERROR = 7'h1E;

    // block type field values.
    localparam logic [7:0] BT_CTRL   = 8'h1E;
    localparam logic [7:0] BT_START0 = 8'h78;
    localparam logic [7:0] BT_START4 = 8'h33;
    localparam logic [7:0] BT_ORDSET = 8'h4B;
    localparam logic [7:0] BT_TERM0  = 8'h87;
    localparam logic [7:0] BT_TERM1  = 8'h99;
    localparam logic [7:0] BT_TERM2  = 8'hAA;
    localparam logic [7:0] BT_TERM3  = 8'hB4;
    localparam logic [7:0] BT_TERM4  = 8'hCC;
    localparam logic [7:0] BT_TERM5  = 8'hD2;
    localparam logic [7:0] BT_TERM6  = 8'hE1;
    localparam logic [7:0] BT_TERM7  = 8'hFF;

    typedef enum logic [NB_BLOCK_TYPE-1:0] {
        CLS_C, CLS_S, CLS_D, CLS_T, CLS_E
    } blk_class_e;

    // fixed lanes carry a character implied by the block type.
    typedef enum logic [1:0] {
        LANE_DATA, LANE_CODE, LANE_FIXED
    } lane_kind_e;

    typedef struct packed {
        lane_kind_e             kind;
        logic [7:0]             octet;
        xgmii_pkg::xgmii_char_t fixed;
    } lane_field_t;

    typedef struct packed {
        blk_class_e                                 cls;
        lane_field_t [xgmii_pkg::NB_CTRL_BLOCK-1:0] lanes;
    } classified_t;

    typedef enum logic [NB_BLOCK_TYPE-1:0] {
        RX_INIT, RX_C, RX_D, RX_T, RX_E
    } rx_state_e;

endpackage

/* src/xgmii_pkg.sv */
package xgmii_pkg;

    // decoded side of the PCS receive path.
    localparam int NB_DATA_RAW   = 64;
    localparam int NB_CTRL_BLOCK = 8;

    typedef logic [NB_DATA_RAW-1:0]   xgmii_data_t;
    typedef logic [NB_CTRL_BLOCK-1:0] xgmii_ctrl_t;

    // one lane character.
    typedef logic [7:0] xgmii_char_t;

    // control characters, as seen on the XGMII.
    localparam xgmii_char_t XGMII_IDLE  = 8'h07;
    localparam xgmii_char_t XGMII_START = 8'hFB;
    localparam xgmii_char_t XGMII_TERM  = 8'hFD;
    localparam xgmii_char_t XGMII_ERROR = 8'hFE;
    localparam xgmii_char_t XGMII_SEQ   = 8'h9C;

    // lane 0 sits in data[7:0] and ctrl[0].
    typedef struct packed {
        xgmii_data_t data;
        xgmii_ctrl_t ctrl;
    } xgmii_word_t;

endpackage

/* testbench/decoder_props.sv */
`timescale 1ns/1ps

module decoder_props (
    input logic                   i_clock,
    input logic                   i_rst_n,
    input logic                   i_enable,
    input xgmii_pkg::xgmii_data_t i_xgmii_data,
    input xgmii_pkg::xgmii_ctrl_t i_xgmii_ctrl,
    input pcs66_pkg::rx_state_e   i_fsm_state
);
    import pcs66_pkg::*;

    // failed assertions so far.
    int failures = 0;

    // state machine held in init while reset is low.
    a_reset_state: assert property (
        @(posedge i_clock) !i_rst_n |-> i_fsm_state == RX_INIT
    ) else begin
        $error("fsm state is not RX_INIT during reset");
        failures++;
    end

    // error block marks every lane as control.
    a_error_ctrl: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_fsm_state == RX_E |-> i_xgmii_ctrl == 8'hFF
    ) else begin
        $error("o_ctrl is not 0xFF in state RX_E");
        failures++;
    end

    // no enable, no movement at the outputs.
    a_hold_outputs: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        !i_enable |=> $stable(i_xgmii_data) && $stable(i_xgmii_ctrl) && $stable(i_fsm_state)
    ) else begin
        $error("outputs changed on an edge with i_enable low");
        failures++;
    end

endmodule

/* testbench/tb_decoder.sv */
`timescale 1ns/1ps

module tb_decoder;
    import pcs66_pkg::*;
    import xgmii_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam logic [7:0] TERM_TYPES [0:7] = '{BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
                                                BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7};

    logic         i_clock;
    logic         i_rst_n;
    logic         i_enable;
    coded_block_t i_data;
    xgmii_data_t  o_data;
    xgmii_ctrl_t  o_ctrl;
    rx_state_e    o_fsm_control;

    integer       seed = 32'h0dfa74ad;
    coded_block_t blocks[$];
    string        names[$];
    xgmii_word_t  exp_words[$];
    rx_state_e    exp_states[$];
    int           inflight[$];
    int           drv_idx = 0;
    int           gap_from = 0;
    int           checked = 0;
    int           value_errors = 0;
    int           other_errors = 0;
    logic         all_checked = 1'b0;
    logic         stim_ready = 1'b0;

    decoder u_dut (.*);

    bind decoder decoder_props u_decoder_props (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_enable),
        .i_xgmii_data (o_data),
        .i_xgmii_ctrl (o_ctrl),
        .i_fsm_state  (o_fsm_control)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic coded_block_t ctrl_blk(logic [7:0] btype, logic [55:0] payload);
        return {payload, btype, SYNC_CTRL};
    endfunction

    function automatic coded_block_t data_blk();
        return {rand64(), SYNC_DATA};
    endfunction

    // start4 keeps idle codes in lanes 0 to 3.
    function automatic coded_block_t start_blk(int lane);
        logic [63:0] r;
        r = rand64();
        if (lane == 0) begin
            return ctrl_blk(BT_START0, r[55:0]);
        end
        return ctrl_blk(BT_START4, {r[23:0], 32'h0});
    endfunction

    // data below lane k, idle codes above it.
    function automatic coded_block_t term_blk(int k);
        logic [63:0] r;
        logic [55:0] mask;
        r    = rand64();
        mask = (56'd1 << (8 * k)) - 56'd1;
        return ctrl_blk(TERM_TYPES[k], r[55:0] & mask);
    endfunction

    function automatic int term_pos(logic [7:0] btype);
        for (int k = 0; k < 8; k++) begin
            if (btype == TERM_TYPES[k]) return k;
        end
        return -1;
    endfunction

    function automatic blk_class_e ref_class(coded_block_t blk);
        if (blk[1:0] == SYNC_DATA) return CLS_D;
        if (blk[1:0] != SYNC_CTRL) return CLS_E;
        if (blk[9:2] == BT_CTRL || blk[9:2] == BT_ORDSET) return CLS_C;
        if (blk[9:2] == BT_START0 || blk[9:2] == BT_START4) return CLS_S;
        if (term_pos(blk[9:2]) >= 0) return CLS_T;
        return CLS_E;
    endfunction

    function automatic xgmii_char_t code_char(logic [6:0] code);
        return (code == 7'h00) ? XGMII_IDLE : XGMII_ERROR;
    endfunction

    // expected word and state for one block, given the class behind it.
    function automatic void ref_decode(input coded_block_t blk, input rx_state_e state,
                                       input blk_class_e next_cls, output xgmii_word_t word,
                                       output rx_state_e new_state);
        blk_class_e cls;
        logic       idle_side;
        logic       data_side;
        int         k;
        cls       = ref_class(blk);
        idle_side = state inside {RX_INIT, RX_C, RX_T, RX_E};
        data_side = state inside {RX_D, RX_E};
        new_state = RX_E;
        case (cls)
            CLS_C: if (idle_side) new_state = RX_C;
            CLS_S: if (idle_side) new_state = RX_D;
            CLS_D: if (data_side) new_state = RX_D;
            CLS_T: if (data_side && next_cls inside {CLS_C, CLS_S}) new_state = RX_T;
            default: new_state = RX_E;
        endcase
        k         = term_pos(blk[9:2]);
        word.ctrl = 8'hFF;
        for (int j = 0; j < 8; j++) begin
            word.data[8*j +: 8] = code_char(blk[10 + 7*j +: 7]);
        end
        if (new_state == RX_E) begin
            word.data = {8{XGMII_ERROR}};
        end else if (cls == CLS_D) begin
            word = {blk[65:2], 8'h00};
        end else if (blk[9:2] == BT_START0) begin
            word = {blk[65:10], XGMII_START, 8'h01};
        end else if (blk[9:2] == BT_START4) begin
            word.data[63:32] = {blk[65:42], XGMII_START};
            word.ctrl        = 8'h1F;
        end else if (blk[9:2] == BT_ORDSET) begin
            word = {{4{XGMII_IDLE}}, blk[33:10], XGMII_SEQ, 8'hF1};
        end else if (k >= 0) begin
            for (int j = 0; j < k; j++) begin
                word.data[8*j +: 8] = blk[10 + 8*j +: 8];
            end
            word.data[8*k +: 8] = XGMII_TERM;
            word.ctrl           = 8'hFF << k;
        end
    endfunction

    task automatic add_block(coded_block_t blk, string name);
        blocks.push_back(blk);
        names.push_back(name);
    endtask

    task automatic add_frame(int start_lane, int n_data, int term);
        string name;
        name = $sformatf("frame_s%0d_t%0d", 4 * start_lane, term);
        add_block(start_blk(start_lane), name);
        repeat (n_data) add_block(data_blk(), name);
        add_block(term_blk(term), name);
        add_block(ctrl_blk(BT_CTRL, 56'h0), name);
    endtask

    task automatic build_stimulus();
        coded_block_t idle;
        logic [63:0]  r;
        idle = ctrl_blk(BT_CTRL, 56'h0);
        r    = rand64();
        repeat (6) add_block(idle, "idle_run");
        for (int k = 0; k < 8; k++) begin
            add_frame(k % 2, 1 + k % 3, k);
        end
        add_block(ctrl_blk(BT_ORDSET, {32'h0, r[23:0]}), "ordered_set");
        add_block(idle, "ordered_set");
        add_block({rand64(), 2'b00}, "bad_sync");
        add_block(idle, "bad_sync");
        add_block(ctrl_blk(8'h55, 56'h0), "bad_type");
        add_block(idle, "bad_type");
        add_block(data_blk(), "data_after_idle");
        add_block(data_blk(), "data_after_idle");
        add_block(term_blk(0), "data_after_idle");
        add_block(idle, "data_after_idle");
        add_block(start_blk(0), "term_then_data");
        add_block(term_blk(3), "term_then_data");
        add_block(data_blk(), "term_then_data");
        add_block(term_blk(0), "term_then_data");
        add_block(idle, "term_then_data");
        gap_from = blocks.size();
        for (int k = 0; k < 8; k++) begin
            add_frame((k + 1) % 2, 2, 7 - k);
        end
        repeat (3) add_block(idle, "flush");
    endtask

    // the two fill blocks carry class E, so block 0 meets state E.
    task automatic compute_expected();
        rx_state_e   state;
        rx_state_e   new_state;
        xgmii_word_t word;
        state = RX_E;
        for (int i = 0; i + 1 < blocks.size(); i++) begin
            ref_decode(blocks[i], state, ref_class(blocks[i + 1]), word, new_state);
            exp_words.push_back(word);
            exp_states.push_back(new_state);
            state = new_state;
        end
    endtask

    // enable drops at random once the gap section starts.
    task automatic drive_blocks();
        int idx;
        idx = 0;
        while (idx < blocks.size()) begin
            @(posedge i_clock);
            #5;
            if (idx >= gap_from && ($random(seed) & 3) == 0) begin
                i_enable = 1'b0;
                i_data   = {rand64(), 2'b11};
            end else begin
                i_enable = 1'b1;
                i_data   = blocks[idx];
                drv_idx  = idx;
                idx++;
            end
        end
        @(posedge i_clock);
        #5;
        i_enable = 1'b0;
    endtask

    task automatic check_block(int idx);
        xgmii_word_t exp;
        rx_state_e   exp_state;
        exp       = exp_words[idx];
        exp_state = exp_states[idx];
        assert (o_data === exp.data) else begin
            $display("[ERROR] %s block %0d: o_data expected %h, actual %h",
                     names[idx], idx, exp.data, o_data);
            value_errors++;
        end
        assert (o_ctrl === exp.ctrl) else begin
            $display("[ERROR] %s block %0d: o_ctrl expected %h, actual %h",
                     names[idx], idx, exp.ctrl, o_ctrl);
            value_errors++;
        end
        assert (o_fsm_control === exp_state) else begin
            $display("[ERROR] %s block %0d: o_fsm_control expected %s, actual %s",
                     names[idx], idx, exp_state.name(), o_fsm_control.name());
            value_errors++;
        end
        checked++;
        if (idx == blocks.size() - 3) all_checked = 1'b1;
    endtask

    // a block reaches the outputs on its third enabled edge.
    initial begin : compare
        int idx;
        forever begin
            @(posedge i_clock);
            if (i_rst_n === 1'b1 && i_enable === 1'b1) begin
                inflight.push_back(drv_idx);
                if (inflight.size() == 3) begin
                    idx = inflight.pop_front();
                    @(negedge i_clock);
                    check_block(idx);
                end
            end
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (stim_ready === 1'b1);
        limit_ns = blocks.size() * 2 * CLK_PERIOD + 20 * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog expired after %0d ns, %0d of %0d blocks checked, %0d value errors",
                 limit_ns, checked, blocks.size() - 2, value_errors);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        i_rst_n  = 1'b1;
        i_enable = 1'b0;
        i_data   = '0;
        build_stimulus();
        compute_expected();
        stim_ready = 1'b1;
        #1 i_rst_n = 1'b0;
        repeat (10) @(posedge i_clock);
        #5 i_rst_n = 1'b1;
        drive_blocks();
        wait (all_checked === 1'b1);
        // bound assertion failures count as errors too.
        other_errors = u_dut.u_decoder_props.failures;
        $display("blocks checked: %0d, value errors: %0d, other errors: %0d",
                 checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
